// ==== rtl/sap_cfg_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// sap core sizes and timing
// data, memory word and address widths, memory depth and access latency
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package sap_cfg_pkg;

    localparam int DATA_WIDTH  = 8;   // accumulator and operand
    localparam int WORD_WIDTH  = 16;  // one memory word holds one instruction
    localparam int ADDR_WIDTH  = 4;
    localparam int MEM_DEPTH   = 16;
    localparam int MEM_LATENCY = 3;   // cycles from req rising to ack rising

    // wide enough to count up to the latency
    localparam int LAT_WIDTH   = $clog2(MEM_LATENCY + 1);

    typedef logic [DATA_WIDTH-1:0] data_t;
    typedef logic [WORD_WIDTH-1:0] word_t;
    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [ADDR_WIDTH:0]   pc_t;  // top bit set once pc runs off the end

endpackage

`default_nettype wire

// ==== rtl/sap_isa_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// sap instruction set
// opcodes, alu operations, branch conditions, instruction layout and the
// request kinds passed from decode to execute
////////////////////////////////////////////////////////////////////////////

`default_nettype none

package sap_isa_pkg;

    // instruction bits 15:12, anything not listed is illegal
    typedef enum logic [3:0] {
        OP_NOOP   = 4'd0,
        OP_LOAD   = 4'd1,
        OP_STORE  = 4'd2,
        OP_MOV    = 4'd3,
        OP_ALU    = 4'd4,
        OP_BRANCH = 4'd5,
        OP_OUT    = 4'd6,
        OP_HLT    = 4'd15
    } opcode_e;

    // bits 11:8 of an ALU instruction
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_PASS = 4'd5   // acc takes the operand
    } alu_op_e;

    // bits 11:8 of a BRANCH, other codes never branch
    typedef enum logic [3:0] {
        BR_EQ   = 4'd0,
        BR_NEQ  = 4'd1,
        BR_GT   = 4'd2,
        BR_GTEQ = 4'd3,
        BR_LT   = 4'd4,
        BR_LTEQ = 4'd5
    } branch_cond_e;

    typedef struct packed {
        opcode_e    opcode;
        logic [3:0] func;     // alu op or branch condition
        logic [7:0] operand;  // immediate, low nibble is the address
    } instr_t;

    typedef enum logic [1:0] {
        EX_SET_OPERAND,
        EX_RUN_ALU,
        EX_LOAD_OUT,
        EX_RESET_ACC
    } exec_kind_e;

endpackage

`default_nettype wire

// ==== rtl/sap_mem_if.sv ====
////////////////////////////////////////////////////////////////////////////
// memory access bus, four-phase req/ack
// requester holds fields stable while req is high, responder answers
// with ack after the memory latency
////////////////////////////////////////////////////////////////////////////

`default_nettype none

interface sap_mem_if import sap_cfg_pkg::*; ();

    logic  req;
    logic  wen;    // 1 write, 0 read
    addr_t addr;
    word_t wdata;
    logic  ack;
    word_t rdata;  // valid while ack is high on a read

    modport requester (output req, wen, addr, wdata, input ack, rdata);
    modport responder (input req, wen, addr, wdata, output ack, rdata);

endinterface

`default_nettype wire

// ==== rtl/sap_exec_if.sv ====
////////////////////////////////////////////////////////////////////////////
// decode to execute request bus
// four-phase req/ack with a one cycle ack, flags and acc come back
////////////////////////////////////////////////////////////////////////////

`default_nettype none

interface sap_exec_if import sap_cfg_pkg::*, sap_isa_pkg::*; ();

    logic       req;
    exec_kind_e kind;
    alu_op_e    alu_op;
    data_t      operand;
    logic       ack;
    logic       zero;
    logic       overflow;
    data_t      acc;      // read by decode for STORE

    modport issuer (output req, kind, alu_op, operand,
                    input  ack, zero, overflow, acc);
    modport unit   (input  req, kind, alu_op, operand,
                    output ack, zero, overflow, acc);

endinterface

`default_nettype wire

// ==== rtl/sap_memory.sv ====
////////////////////////////////////////////////////////////////////////////
// unified program and data memory
// core accesses go through the req/ack handshake with a fixed latency,
// the program port writes directly in one cycle
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module sap_memory import sap_cfg_pkg::*; (
    input  wire logic  clk,
    input  wire logic  a_reset_n,
    input  wire logic  prog_wen,
    input  wire addr_t prog_addr,
    input  wire word_t prog_data,
    sap_mem_if.responder bus
);

    word_t                mem [MEM_DEPTH];
    logic [LAT_WIDTH-1:0] lat_cnt;
    logic                 access_done;

    // last wait cycle of an access, ack rises on the next edge
    assign access_done = bus.req && !bus.ack &&
                         (lat_cnt == LAT_WIDTH'(MEM_LATENCY - 1));

    ////////////////////////////////////////////////////////////////////////////
    // handshake and latency counter

    always_ff @(posedge clk or negedge a_reset_n) begin
        if (!a_reset_n) begin
            lat_cnt <= '0;
            bus.ack <= 1'b0;
        end else if (bus.ack) begin
            if (!bus.req)
                bus.ack <= 1'b0;  // requester let go, close the cycle
        end else if (access_done) begin
            lat_cnt <= '0;
            bus.ack <= 1'b1;
        end else if (bus.req) begin
            lat_cnt <= lat_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // storage

    always_ff @(posedge clk) begin
        if (access_done) begin
            if (bus.wen)
                mem[bus.addr] <= bus.wdata;  // write lands as ack rises
            else
                bus.rdata <= mem[bus.addr];
        end else if (prog_wen && !bus.req && !bus.ack) begin
            mem[prog_addr] <= prog_data;     // core access has priority
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sap_decode.sv ====
////////////////////////////////////////////////////////////////////////////
// instruction sequencer
// fetch, decode and execute of one instruction at a time, owns the pc,
// the instruction register, branch decisions and the error state
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module sap_decode import sap_cfg_pkg::*, sap_isa_pkg::*; (
    input  wire logic clk,
    input  wire logic a_reset_n,
    input  wire logic start,
    sap_mem_if.requester mem,
    sap_exec_if.issuer   exe,
    input  wire logic prog_wen,
    output logic      halted,
    output logic      error
);

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_FETCH,
        ST_DECODE,
        ST_OPERAND,  // data read for LOAD
        ST_STORE,
        ST_BRANCH,
        ST_EXEC,
        ST_HALTED,
        ST_ERROR
    } state_e;

    state_e state;
    pc_t    pc;
    instr_t ir;
    logic   start_q;
    logic   start_edge;
    logic   br_taken;

    assign start_edge = start && !start_q;
    assign halted     = (state == ST_HALTED);
    assign error      = (state == ST_ERROR);

    // memory fields follow the state, stable while req is high
    assign mem.wen   = (state == ST_STORE);
    assign mem.addr  = (state == ST_FETCH) ? pc[ADDR_WIDTH-1:0] : ir.operand[ADDR_WIDTH-1:0];
    assign mem.wdata = {{(WORD_WIDTH - DATA_WIDTH){1'b0}}, exe.acc};

    ////////////////////////////////////////////////////////////////////////////
    // branch condition

    always_comb begin
        case (branch_cond_e'(ir.func))
            BR_EQ:   br_taken = exe.zero;
            BR_NEQ:  br_taken = !exe.zero;
            BR_GT:   br_taken = !exe.zero && !exe.overflow;
            BR_GTEQ: br_taken = !exe.overflow;
            BR_LT:   br_taken = !exe.zero && exe.overflow;
            BR_LTEQ: br_taken = exe.overflow;
            default: br_taken = 1'b0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // state machine, pc and request lines

    always_ff @(posedge clk or negedge a_reset_n) begin
        if (!a_reset_n) begin
            state   <= ST_IDLE;
            pc      <= '0;
            start_q <= 1'b0;
            mem.req <= 1'b0;
            exe.req <= 1'b0;
        end else begin
            start_q <= start;
            case (state)
                ST_IDLE, ST_HALTED: begin
                    if (start_edge && !prog_wen) begin
                        pc    <= '0;
                        state <= ST_EXEC;  // clear acc, operand and flags first
                    end
                end
                ST_FETCH: begin
                    if (!mem.req) begin
                        if (pc == pc_t'(MEM_DEPTH))
                            state <= ST_ERROR;  // ran off the last word
                        else if (!mem.ack)
                            mem.req <= 1'b1;
                    end else if (mem.ack) begin
                        mem.req <= 1'b0;
                        pc      <= pc + 1'b1;
                        state   <= ST_DECODE;
                    end
                end
                ST_DECODE: begin
                    case (ir.opcode)
                        OP_NOOP:               state <= ST_FETCH;
                        OP_LOAD:               state <= ST_OPERAND;
                        OP_STORE:              state <= ST_STORE;
                        OP_MOV, OP_ALU, OP_OUT: state <= ST_EXEC;
                        OP_BRANCH:             state <= ST_BRANCH;
                        OP_HLT:                state <= ST_HALTED;
                        default:               state <= ST_ERROR;
                    endcase
                end
                ST_OPERAND, ST_STORE: begin
                    if (!mem.req && !mem.ack) begin
                        mem.req <= 1'b1;
                    end else if (mem.req && mem.ack) begin
                        mem.req <= 1'b0;
                        state   <= (state == ST_OPERAND) ? ST_EXEC : ST_FETCH;
                    end
                end
                ST_BRANCH: begin
                    if (br_taken)
                        pc <= {1'b0, ir.operand[ADDR_WIDTH-1:0]};
                    state <= ST_FETCH;
                end
                ST_EXEC: begin
                    if (!exe.req && !exe.ack) begin
                        exe.req <= 1'b1;
                    end else if (exe.req && exe.ack) begin
                        exe.req <= 1'b0;
                        state   <= ST_FETCH;
                    end
                end
                default: state <= ST_ERROR;  // ST_ERROR holds until reset
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // instruction register and execute request fields

    always_ff @(posedge clk) begin
        case (state)
            ST_IDLE, ST_HALTED: exe.kind <= EX_RESET_ACC;
            ST_FETCH: begin
                if (mem.req && mem.ack)
                    ir <= mem.rdata;
            end
            ST_DECODE: begin
                exe.alu_op  <= alu_op_e'(ir.func);
                exe.operand <= ir.operand;  // MOV immediate
                case (ir.opcode)
                    OP_ALU:  exe.kind <= EX_RUN_ALU;
                    OP_OUT:  exe.kind <= EX_LOAD_OUT;
                    default: exe.kind <= EX_SET_OPERAND;
                endcase
            end
            ST_OPERAND: begin
                if (mem.req && mem.ack)
                    exe.operand <= mem.rdata[DATA_WIDTH-1:0];
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/sap_execute.sv ====
////////////////////////////////////////////////////////////////////////////
// execute unit
// accumulator, operand register, alu with zero and overflow flags, and
// the output register
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module sap_execute import sap_cfg_pkg::*, sap_isa_pkg::*; (
    input  wire logic clk,
    input  wire logic a_reset_n,
    sap_exec_if.unit  exe,
    output data_t     out_data,
    output logic      out_valid
);

    data_t               acc;
    data_t               opnd;
    logic                zero_q;
    logic                ovf_q;
    logic                fire;
    logic                alu_hit;
    logic [DATA_WIDTH:0] alu_wide;  // top bit is carry or borrow

    assign fire         = exe.req && !exe.ack;
    assign exe.acc      = acc;
    assign exe.zero     = zero_q;
    assign exe.overflow = ovf_q;

    always_comb begin
        alu_hit = 1'b1;
        case (exe.alu_op)
            ALU_ADD:  alu_wide = {1'b0, acc} + {1'b0, opnd};
            ALU_SUB:  alu_wide = {1'b0, acc} - {1'b0, opnd};
            ALU_AND:  alu_wide = {1'b0, acc & opnd};
            ALU_OR:   alu_wide = {1'b0, acc | opnd};
            ALU_XOR:  alu_wide = {1'b0, acc ^ opnd};
            ALU_PASS: alu_wide = {1'b0, opnd};
            default: begin
                alu_wide = {1'b0, acc};
                alu_hit  = 1'b0;  // unknown op leaves acc and flags alone
            end
        endcase
    end

    always_ff @(posedge clk or negedge a_reset_n) begin
        if (!a_reset_n) begin
            exe.ack   <= 1'b0;
            acc       <= '0;
            opnd      <= '0;
            zero_q    <= 1'b0;
            ovf_q     <= 1'b0;
            out_data  <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            if (fire) begin
                exe.ack <= 1'b1;  // act once, as ack rises
                case (exe.kind)
                    EX_SET_OPERAND: opnd <= exe.operand;
                    EX_RUN_ALU: begin
                        if (alu_hit) begin
                            acc    <= alu_wide[DATA_WIDTH-1:0];
                            zero_q <= (alu_wide[DATA_WIDTH-1:0] == '0);
                            ovf_q  <= alu_wide[DATA_WIDTH];
                        end
                    end
                    EX_LOAD_OUT: begin
                        out_data  <= acc;
                        out_valid <= 1'b1;
                    end
                    default: begin  // EX_RESET_ACC, out_data is kept
                        acc    <= '0;
                        opnd   <= '0;
                        zero_q <= 1'b0;
                        ovf_q  <= 1'b0;
                    end
                endcase
            end else if (exe.ack && !exe.req) begin
                exe.ack <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/sap_core.sv ====
////////////////////////////////////////////////////////////////////////////
// sap core top level
// memory, sequencer and execute unit joined by their buses
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module sap_core import sap_cfg_pkg::*; (
    input  wire logic  clk,
    input  wire logic  a_reset_n,
    input  wire logic  start,
    input  wire logic  prog_wen,    // only while idle or halted
    input  wire addr_t prog_addr,
    input  wire word_t prog_data,
    output wire data_t out_data,
    output wire logic  out_valid,
    output wire logic  halted,
    output wire logic  error
);

    sap_mem_if  mem_bus ();
    sap_exec_if exe_bus ();

    sap_memory u_memory (
        .clk       (clk),
        .a_reset_n (a_reset_n),
        .prog_wen  (prog_wen),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .bus       (mem_bus.responder)
    );

    sap_decode u_decode (
        .clk       (clk),
        .a_reset_n (a_reset_n),
        .start     (start),
        .mem       (mem_bus.requester),
        .exe       (exe_bus.issuer),
        .prog_wen  (prog_wen),
        .halted    (halted),
        .error     (error)
    );

    sap_execute u_execute (
        .clk       (clk),
        .a_reset_n (a_reset_n),
        .exe       (exe_bus.unit),
        .out_data  (out_data),
        .out_valid (out_valid)
    );

endmodule

`default_nettype wire

// ==== include/sap_tb_tests.svh ====
////////////////////////////////////////////////////////////////////////////
// sap core directed tests
// programs, reference model and expected output lists
////////////////////////////////////////////////////////////////////////////

`ifndef SAP_TB_TESTS_SVH
`define SAP_TB_TESTS_SVH

localparam logic [3:0] OPC_NOOP = 4'd0, OPC_LOAD = 4'd1, OPC_STORE = 4'd2;
localparam logic [3:0] OPC_MOV = 4'd3, OPC_ALU = 4'd4, OPC_BRANCH = 4'd5;
localparam logic [3:0] OPC_OUT = 4'd6, OPC_HLT = 4'd15;
localparam logic [3:0] FN_ADD = 4'd0, FN_SUB = 4'd1, FN_AND = 4'd2;
localparam logic [3:0] FN_OR = 4'd3, FN_XOR = 4'd4, FN_PASS = 4'd5;

logic [7:0] m_acc;  // reference accumulator

function automatic logic [15:0] encode_instr(input logic [3:0] op, input logic [3:0] fn,
                                             input logic [7:0] opnd);
    return {op, fn, opnd};
endfunction

function automatic void model_alu(input logic [3:0] op, input logic [7:0] opnd);
    case (op)
        FN_ADD:  m_acc = m_acc + opnd;
        FN_SUB:  m_acc = m_acc - opnd;
        FN_AND:  m_acc = m_acc & opnd;
        FN_OR:   m_acc = m_acc | opnd;
        FN_XOR:  m_acc = m_acc ^ opnd;
        FN_PASS: m_acc = opnd;
        default: ;
    endcase
endfunction

task automatic new_program();
    foreach (prog[i])
        prog[i] = encode_instr(OPC_NOOP, 4'd0, 8'(i));  // NOOP tagged with its address
    exp_out.delete();
    m_acc = 8'd0;
endtask

// MOV, ALU and OUT at pc along with the expected output
task automatic add_alu_step(inout int pc, input logic [3:0] op, input logic [7:0] val);
    prog[pc]     = encode_instr(OPC_MOV, 4'd0, val);
    prog[pc + 1] = encode_instr(OPC_ALU, op, 8'd0);
    prog[pc + 2] = encode_instr(OPC_OUT, 4'd0, 8'd0);
    pc += 3;
    model_alu(op, val);
    exp_out.push_back(m_acc);
endtask

task automatic arithmetic_ops();
    int pc;
    logic [3:0] ops [7] = '{FN_PASS, FN_ADD, FN_SUB, FN_PASS, FN_AND, FN_OR, FN_XOR};
    new_program();
    pc = 0;
    for (int i = 0; i < 3; i++) add_alu_step(pc, ops[i], 8'($urandom()));
    prog[pc] = encode_instr(OPC_HLT, 4'd0, 8'd0);
    run_program();
    check_outputs("arith add/sub");
    new_program();
    pc = 0;
    for (int i = 3; i < 7; i++) add_alu_step(pc, ops[i], 8'($urandom()));
    prog[pc] = encode_instr(OPC_HLT, 4'd0, 8'd0);
    run_program();
    check_outputs("arith logic");
endtask

task automatic store_and_load();
    logic [7:0] v;
    int pc;
    v = 8'($urandom_range(16, 255));  // never the low byte of a fill word
    new_program();
    pc = 0;
    add_alu_step(pc, FN_PASS, v);
    prog[3] = encode_instr(OPC_STORE, 4'd0, 8'd14);
    prog[4] = encode_instr(OPC_MOV, 4'd0, ~v);
    prog[5] = encode_instr(OPC_ALU, FN_PASS, 8'd0);  // acc overwritten
    prog[6] = encode_instr(OPC_LOAD, 4'd0, 8'd14);
    prog[7] = encode_instr(OPC_ALU, FN_PASS, 8'd0);
    prog[8] = encode_instr(OPC_OUT, 4'd0, 8'd0);
    prog[9] = encode_instr(OPC_HLT, 4'd0, 8'd0);
    exp_out.push_back(v);
    run_program();
    check_outputs("memory");
endtask

task automatic countdown_loop();
    new_program();
    prog[0] = encode_instr(OPC_MOV, 4'd0, 8'd5);
    prog[1] = encode_instr(OPC_ALU, FN_PASS, 8'd0);
    prog[2] = encode_instr(OPC_OUT, 4'd0, 8'd0);    // loop top
    prog[3] = encode_instr(OPC_MOV, 4'd0, 8'd1);
    prog[4] = encode_instr(OPC_ALU, FN_SUB, 8'd0);
    prog[5] = encode_instr(OPC_BRANCH, 4'd1, 8'd2);  // NEQ
    prog[6] = encode_instr(OPC_OUT, 4'd0, 8'd0);
    prog[7] = encode_instr(OPC_HLT, 4'd0, 8'd0);
    for (int i = 5; i >= 0; i--) exp_out.push_back(8'(i));
    run_program();
    check_outputs("countdown");
endtask

// flags come from SUB a-b or from an ADD that carries out to exactly zero
// the output is ff when the branch is taken and 00 when it is not
task automatic branch_conditions();
    logic [7:0] lo;
    logic [7:0] hi;
    logic [7:0] a;
    logic [7:0] b;
    logic [3:0] fn;
    int         sum;
    logic       z;
    logic       o;
    logic       taken;
    lo = 8'($urandom_range(0, 127));
    hi = lo + 8'd1 + 8'($urandom_range(0, 100));
    for (int c = 0; c < 6; c++) begin
        for (int k = 0; k < 4; k++) begin
            if (k == 3) begin
                fn  = FN_ADD;
                a   = hi;
                b   = 8'(256 - int'(hi));
                sum = int'(a) + int'(b);
                z   = (sum % 256 == 0);
                o   = (sum > 255);  // carry
            end else begin
                fn = FN_SUB;
                a  = (k == 2) ? lo : hi;
                b  = (k == 1) ? lo : hi;
                z  = (a == b);
                o  = (a < b);  // borrow
            end
            case (c)
                0: taken = z;
                1: taken = !z;
                2: taken = !z && !o;
                3: taken = !o;
                4: taken = !z && o;
                default: taken = o;
            endcase
            new_program();
            prog[0]  = encode_instr(OPC_MOV, 4'd0, a);
            prog[1]  = encode_instr(OPC_ALU, FN_PASS, 8'd0);
            prog[2]  = encode_instr(OPC_MOV, 4'd0, b);
            prog[3]  = encode_instr(OPC_ALU, fn, 8'd0);
            prog[4]  = encode_instr(OPC_BRANCH, 4'(c), 8'd9);
            prog[5]  = encode_instr(OPC_MOV, 4'd0, 8'h00);
            prog[6]  = encode_instr(OPC_ALU, FN_PASS, 8'd0);
            prog[7]  = encode_instr(OPC_OUT, 4'd0, 8'd0);
            prog[8]  = encode_instr(OPC_HLT, 4'd0, 8'd0);
            prog[9]  = encode_instr(OPC_MOV, 4'd0, 8'hff);  // taken path
            prog[10] = encode_instr(OPC_ALU, FN_PASS, 8'd0);
            prog[11] = encode_instr(OPC_OUT, 4'd0, 8'd0);
            prog[12] = encode_instr(OPC_HLT, 4'd0, 8'd0);
            exp_out.push_back(taken ? 8'hff : 8'h00);
            run_program();
            check_outputs($sformatf("branch cond %0d case %0d", c, k));
        end
    end
endtask

task automatic halt_and_restart();
    logic [7:0] r;
    int pc;
    r = 8'($urandom_range(1, 127));  // ADD onto a stale acc would give 2r
    new_program();
    pc = 0;
    add_alu_step(pc, FN_ADD, r);
    prog[pc] = encode_instr(OPC_HLT, 4'd0, 8'd0);
    run_program();
    check_eq("halted", 32'd1, 32'(halted));
    repeat (30) @(negedge clk);
    check_eq("halted", 32'd1, 32'(halted));
    check_eq("out_data", 32'(exp_out[0]), 32'(out_data));  // held after the last OUT
    check_outputs("after halt");
    start_and_wait();
    check_eq("halted", 32'd1, 32'(halted));
    check_outputs("restart");
endtask

task automatic error_cases();
    logic [7:0] x;
    int pc;
    x = 8'($urandom());
    new_program();
    pc = 0;
    add_alu_step(pc, FN_PASS, x);
    prog[3] = 16'h7000;  // opcode 7 is illegal
    prog[4] = encode_instr(OPC_OUT, 4'd0, 8'd0);
    prog[5] = encode_instr(OPC_HLT, 4'd0, 8'd0);
    run_program();
    repeat (30) @(negedge clk);
    check_eq("error", 32'd1, 32'(error));
    check_eq("halted", 32'd0, 32'(halted));
    check_outputs("illegal opcode");
    apply_reset();
    @(negedge clk);
    check_eq("error", 32'd0, 32'(error));
    new_program();
    pc = 0;
    add_alu_step(pc, FN_PASS, x + 8'd1);  // no HLT so the pc runs off the end
    run_program();
    check_eq("error", 32'd1, 32'(error));
    check_outputs("run off end");
endtask

`endif

// ==== verif/sap_tb_top.sv ====
////////////////////////////////////////////////////////////////////////////
// sap core testbench
// clock, reset, program loader, output collector and directed tests
////////////////////////////////////////////////////////////////////////////

`default_nettype none

module sap_tb_top import sap_cfg_pkg::*; ();

    // upper bound on instructions executed by all tests
    localparam int EXEC_INSTR     = 310;
    localparam int TIMEOUT_CYCLES = 200 * EXEC_INSTR;

    logic  clk;
    logic  a_reset_n;
    logic  start;
    logic  prog_wen;
    addr_t prog_addr;
    word_t prog_data;
    data_t out_data;
    logic  out_valid;
    logic  halted;
    logic  error;

    word_t      prog [MEM_DEPTH];
    logic [7:0] got [$];      // outputs seen in the current run
    logic [7:0] exp_out [$];

    sap_core i_sap_core (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(negedge clk) begin
        if (out_valid)
            got.push_back(out_data);
    end

    initial begin
        #(4 * TIMEOUT_CYCLES);
        $display("watchdog expired after %0d cycles, the core never finished", TIMEOUT_CYCLES);
        $display("Test FAILED");
        $fatal(1);
    end

    task automatic check_eq(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] t=%0t %s expected %0h got %0h", $time, name, expected, actual);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1 a_reset_n = 1'b0;
        repeat (8) @(posedge clk);
        #1 a_reset_n = 1'b1;
    endtask

    task automatic start_and_wait();
        got.delete();
        @(posedge clk);
        #1 start = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
        do @(negedge clk); while (!(halted || error));
        repeat (4) @(negedge clk);
    endtask

    task automatic run_program();
        for (int i = 0; i < MEM_DEPTH; i++) begin
            @(posedge clk);
            #1 prog_wen = 1'b1;
            prog_addr = addr_t'(i);
            prog_data = prog[i];
        end
        @(posedge clk);
        #1 prog_wen = 1'b0;
        start_and_wait();
    endtask

    task automatic check_outputs(input string name);
        check_eq({name, " out count"}, 32'(exp_out.size()), 32'(got.size()));
        foreach (exp_out[i])
            check_eq({name, " out_data"}, 32'(exp_out[i]), 32'(got[i]));
    endtask

    `include "sap_tb_tests.svh"

    initial begin
        a_reset_n = 1'b0;
        start     = 1'b0;
        prog_wen  = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        void'($urandom(32'hc8cc_17d1));
        apply_reset();
        @(negedge clk);
        check_eq("halted", 32'd0, 32'(halted));
        check_eq("error", 32'd0, 32'(error));
        check_eq("out_valid", 32'd0, 32'(out_valid));
        check_eq("out_data", 32'd0, 32'(out_data));
        arithmetic_ops();
        store_and_load();
        countdown_loop();
        branch_conditions();
        halt_and_restart();
        error_cases();
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
+incdir+include
rtl/sap_cfg_pkg.sv
rtl/sap_isa_pkg.sv
rtl/sap_mem_if.sv
rtl/sap_exec_if.sv
rtl/sap_memory.sv
rtl/sap_decode.sv
rtl/sap_execute.sv
rtl/sap_core.sv
verif/sap_tb_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the sap_core testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --top-module sap_tb_top -f files.f -Mdir obj_dir -o sim_bin
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_bin > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Test OK" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
